// ==== verilog/pdpIsaPkg.sv ====
package pdpIsaPkg;

    // one PDP-8 memory word
    typedef logic [11:0] wordT;

    // top three instruction bits
    typedef enum logic [2:0] {
        opAnd = 3'o0,
        opTad = 3'o1,
        opIsz = 3'o2,
        opDca = 3'o3,
        opJms = 3'o4,
        opJmp = 3'o5,
        opIot = 3'o6,
        opOpr = 3'o7
    } opcodeT;

    localparam wordT autoIndexBase = 12'o0010;  // 0010..0017 increment on indirect

    // memory reference instruction bits
    localparam int indirectBit    = 8;
    localparam int currentPageBit = 7;

    // operate instruction bits
    localparam int oprGroupBit = 8;   // set for group 2
    localparam int claBit      = 7;
    localparam int cllBit      = 6;
    localparam int cmaBit      = 5;
    localparam int cmlBit      = 4;
    localparam int rarBit      = 3;
    localparam int ralBit      = 2;
    localparam int twiceBit    = 1;   // rotate by two
    localparam int iacBit      = 0;

endpackage

// ==== verilog/shadowPkg.sv ====
package shadowPkg;

    // where we are inside one memory cycle
    typedef enum logic [2:0] {
        tsUnknown,
        ts1,        // memory read
        ts2,        // writeback computed
        ts3,        // memory write, registers updated
        ts4         // next major state chosen
    } timeStateT;

    typedef enum logic [2:0] {
        msUnknown,
        msFetch,
        msDefer,
        msExec,
        msStart     // cycle right after a bus init
    } majorStateT;

    // cpu outputs as the checker sees them
    typedef struct packed {
        logic              ts1;
        logic              ts3;
        logic              busInit;
        logic              run;
        logic              deferN;
        pdpIsaPkg::wordT   ma;
        pdpIsaPkg::wordT   memN;    // read data, active low
        pdpIsaPkg::wordT   mb;
        pdpIsaPkg::wordT   ac;
    } pdpBusT;

    // one-step strobes from the time state tracker
    typedef struct packed {
        logic decide;
        logic verify;
        logic predict;
        logic compare;
        logic endTs3;
        logic acCapture;
        logic endTs4;
    } phaseT;

    typedef struct packed {
        logic tsOverlap;
        logic maMismatch;
        logic ts1InTs2;
        logic lostState;
        logic stateMismatch;
        logic badExec;
        logic mbMismatch;
        logic ts3InTs4;
        logic acMismatch;
    } errorBitsT;

endpackage

// ==== verilog/cycleTimer.sv ====
`timescale 1ns/1ps

module cycleTimer #(
    parameter int COUNT_WIDTH = 4
) (
    input  logic                   i_CLOCK,
    input  logic                   i_RESET,
    input  logic                   i_step,
    input  logic                   i_clear,   // new time state starts
    output logic [COUNT_WIDTH-1:0] o_count
);

    // steps spent in the current time state, stands in for the ns delay
    always_ff @(posedge i_CLOCK) begin
        if (i_RESET) begin
            o_count <= '0;
        end else if (i_step) begin
            if (i_clear) begin
                o_count <= '0;
            end else if (o_count != '1) begin
                o_count <= o_count + 1'b1;    // saturate at top
            end
        end
    end

endmodule

// ==== verilog/timeStateTracker.sv ====
`timescale 1ns/1ps

module timeStateTracker import shadowPkg::*; #(
    parameter int DECIDE_STEP = 8,
    parameter int COUNT_WIDTH = 4
) (
    input  logic                   i_CLOCK,
    input  logic                   i_RESET,
    input  logic                   i_step,
    input  pdpBusT                 i_bus,
    input  logic [COUNT_WIDTH-1:0] i_count,
    input  errorBitsT              i_raise,     // flags from the other units
    output logic                   o_clear,
    output timeStateT              o_timeState,
    output phaseT                  o_phase,
    output errorBitsT              o_errorBits,
    output logic                   o_error
);

    localparam int CAPTURE_STEP = 8;    // ac settled this far into TS4

    logic      lastTs1, lastTs3;
    logic      active, overlap, countFull;
    timeStateT nextState;
    errorBitsT busRaise;

    assign o_error   = |o_errorBits;
    assign active    = i_step & ~i_bus.busInit & ~o_error;    // frozen once any flag is up
    assign overlap   = (i_bus.ts1 | lastTs1) & (i_bus.ts3 | lastTs3);
    assign countFull = &i_count;
    assign o_clear   = active & ((nextState != o_timeState) | (o_timeState == tsUnknown));

    always_comb begin
        nextState = o_timeState;
        if (!overlap) begin
            case (o_timeState)
                tsUnknown: begin
                    // sync on whichever strobe edge shows up first
                    if (~lastTs1 & i_bus.ts1) nextState = ts1;
                    else if (lastTs1 & ~i_bus.ts1) nextState = ts2;
                    else if (~lastTs3 & i_bus.ts3) nextState = ts3;
                    else if (lastTs3 & ~i_bus.ts3) nextState = ts4;
                end
                ts1: if (!i_bus.ts1) nextState = ts2;
                ts2: if (i_bus.ts3) nextState = ts3;
                ts3: if (!i_bus.ts3) nextState = ts4;
                ts4: begin
                    if (i_bus.ts1) nextState = ts1;
                    else if (countFull & ~i_bus.run) nextState = tsUnknown;   // halted
                end
                default: nextState = tsUnknown;
            endcase
        end
    end

    // bus faults seen here directly
    always_comb begin
        busRaise           = '0;
        busRaise.tsOverlap = overlap;
        busRaise.ts1InTs2  = (o_timeState == ts2) & i_bus.ts1;
        busRaise.ts3InTs4  = (o_timeState == ts4) & i_bus.ts3;
    end

    always_comb begin
        o_phase = '0;
        if (active & ~overlap) begin
            if ((o_timeState == ts3) & i_bus.ts3) begin
                o_phase.decide  = int'(i_count) == DECIDE_STEP;
                o_phase.verify  = int'(i_count) == DECIDE_STEP + 1;
                o_phase.predict = int'(i_count) == DECIDE_STEP + 2;
                o_phase.compare = int'(i_count) == DECIDE_STEP + 3;
            end
            o_phase.endTs3    = (o_timeState == ts3) & ~i_bus.ts3;
            o_phase.acCapture = (o_timeState == ts4) & ~i_bus.ts1
                                & (int'(i_count) == CAPTURE_STEP);
            o_phase.endTs4    = (o_timeState == ts4) & i_bus.ts1;
        end
    end

    always_ff @(posedge i_CLOCK) begin
        if (i_RESET) begin
            o_timeState <= tsUnknown;
            o_errorBits <= '0;
            lastTs1     <= 1'b0;
            lastTs3     <= 1'b0;
        end else if (i_step) begin
            lastTs1 <= i_bus.ts1;
            lastTs3 <= i_bus.ts3;
            if (i_bus.busInit) begin
                o_timeState <= tsUnknown;
                o_errorBits <= '0;      // only a bus init clears the flags
            end else if (!o_error) begin
                o_timeState <= nextState;
                o_errorBits <= o_errorBits | busRaise | i_raise;
            end
        end
    end

endmodule

// ==== verilog/majorStateUnit.sv ====
`timescale 1ns/1ps

module majorStateUnit import pdpIsaPkg::*, shadowPkg::*; (
    input  logic       i_CLOCK,
    input  logic       i_RESET,
    input  pdpBusT     i_bus,
    input  phaseT      i_phase,
    input  logic       i_irKnown,
    input  wordT       i_ir,
    output majorStateT o_majorState,
    output errorBitsT  o_raise
);

    majorStateT predicted;   // guess for the next cycle, made at end of TS4
    majorStateT followed;    // what the previous state and ir lead to
    majorStateT decided;

    function automatic majorStateT follow(majorStateT prev, logic irKnown, wordT ir);
        opcodeT op;
        op     = opcodeT'(ir[11:9]);
        follow = msUnknown;
        case (prev)
            msFetch: begin
                if (irKnown) begin
                    if (op <= opJms) follow = ir[indirectBit] ? msDefer : msExec;
                    else if ((op == opJmp) && ir[indirectBit]) follow = msDefer;
                    else follow = msFetch;     // direct jmp, iot, opr
                end
            end
            msDefer: if (irKnown) follow = (op == opJmp) ? msFetch : msExec;
            msExec, msStart: follow = msFetch;
            default: follow = msUnknown;
        endcase
    endfunction

    assign followed = follow(o_majorState, i_irKnown, i_ir);

    always_comb begin
        if (!i_bus.deferN) decided = msDefer;           // cpu says so directly
        else if (followed != msUnknown) decided = followed;
        else decided = predicted;                       // fall back on the guess
    end

    always_comb begin
        o_raise               = '0;
        o_raise.lostState     = i_phase.decide & (decided == msUnknown)
                                & (o_majorState != msUnknown);
        // decided state must agree with the guess when both are known
        o_raise.stateMismatch = i_phase.verify & (o_majorState != msUnknown)
                                & (predicted != msUnknown) & (o_majorState != predicted);
    end

    always_ff @(posedge i_CLOCK) begin
        if (i_RESET) begin
            o_majorState <= msUnknown;
            predicted    <= msUnknown;
        end else if (i_bus.busInit) begin
            o_majorState <= msStart;
            predicted    <= msFetch;
        end else begin
            if (i_phase.decide) o_majorState <= decided;
            if (i_phase.endTs4) predicted <= followed;
        end
    end

endmodule

// ==== verilog/shadowRegisters.sv ====
`timescale 1ns/1ps

module shadowRegisters import pdpIsaPkg::*, shadowPkg::*; (
    input  logic       i_CLOCK,
    input  logic       i_RESET,
    input  pdpBusT     i_bus,
    input  phaseT      i_phase,
    input  majorStateT i_majorState,
    output logic       o_irKnown,
    output wordT       o_ir,
    output errorBitsT  o_raise
);

    wordT        ac, pc, ea;
    logic        link;
    logic        acKnown, pcKnown, eaKnown;
    wordT        expMa, expMb;       // expected address and writeback
    logic        maKnown, mbKnown;
    wordT        word;               // memory data as read
    wordT        autoInc;
    opcodeT      op;
    logic [12:0] g1Raw, g1Out;       // link and ac for a group 1 opr

    assign word    = ~i_bus.memN;
    assign op      = opcodeT'(o_ir[11:9]);
    assign autoInc = word + ((i_bus.ma[11:3] == autoIndexBase[11:3]) ? 12'd1 : 12'd0);

    // group 1 order is clears, complements, iac, then rotate
    always_comb begin
        g1Raw = {o_ir[cllBit] ? 1'b0 : link, o_ir[claBit] ? 12'o0000 : ac};
        g1Raw = g1Raw ^ {o_ir[cmlBit], {12{o_ir[cmaBit]}}};
        g1Raw = g1Raw + 13'(o_ir[iacBit]);          // carry goes into link
        case ({o_ir[rarBit], o_ir[ralBit], o_ir[twiceBit]})
            3'b100:  g1Out = {g1Raw[0], g1Raw[12:1]};        // rar
            3'b101:  g1Out = {g1Raw[1:0], g1Raw[12:2]};      // rtr
            3'b010:  g1Out = {g1Raw[11:0], g1Raw[12]};       // ral
            3'b011:  g1Out = {g1Raw[10:0], g1Raw[12:11]};    // rtl
            default: g1Out = g1Raw;
        endcase
    end

    always_comb begin
        o_raise            = '0;
        o_raise.maMismatch = i_phase.compare & maKnown & (expMa != i_bus.ma);
        o_raise.mbMismatch = i_phase.compare & mbKnown & (expMb != i_bus.mb);
        o_raise.badExec    = i_phase.predict & (i_majorState == msExec) & o_irKnown
                             & (op > opJms);
        // skips are not followed
        o_raise.lostState  = i_phase.endTs3 & (i_majorState == msFetch) & o_irKnown
                             & (op == opOpr) & o_ir[oprGroupBit];
        o_raise.acMismatch = i_phase.endTs4 & acKnown & (i_bus.ac != ac);
    end

    always_ff @(posedge i_CLOCK) begin
        if (i_RESET) begin
            acKnown   <= 1'b0;
            pcKnown   <= 1'b0;
            eaKnown   <= 1'b0;
            o_irKnown <= 1'b0;
            maKnown   <= 1'b0;
            mbKnown   <= 1'b0;
        end else if (i_bus.busInit) begin
            ac        <= '0;      // start clears ac and link
            link      <= 1'b0;
            acKnown   <= 1'b1;
            pcKnown   <= 1'b0;
            eaKnown   <= 1'b0;
            o_irKnown <= 1'b0;
            maKnown   <= 1'b0;
            mbKnown   <= 1'b0;
        end else if (i_phase.verify) begin
            if (i_majorState == msFetch) begin
                o_ir      <= word;
                o_irKnown <= 1'b1;
                ea[11:7]  <= word[currentPageBit] ? i_bus.ma[11:7] : 5'b0;
                ea[6:0]   <= word[6:0];
                eaKnown   <= 1'b1;
                if (!pcKnown) begin
                    pc      <= i_bus.ma;       // first fetch teaches us the pc
                    pcKnown <= 1'b1;
                end
            end
        end else if (i_phase.predict) begin
            maKnown <= 1'b0;
            mbKnown <= 1'b0;
            case (i_majorState)
                msFetch: begin
                    expMa   <= pc;
                    maKnown <= pcKnown;
                    expMb   <= word;                  // fetch writes back unchanged
                    mbKnown <= 1'b1;
                end
                msDefer: begin
                    expMa   <= ea;
                    maKnown <= eaKnown;
                    expMb   <= autoInc;
                    mbKnown <= 1'b1;
                    ea      <= autoInc;               // pointer becomes operand address
                    eaKnown <= 1'b1;
                end
                msExec: begin
                    expMa   <= ea;
                    maKnown <= eaKnown;
                    if (o_irKnown) begin
                        case (op)
                            opAnd, opTad: begin
                                expMb   <= word;
                                mbKnown <= 1'b1;
                            end
                            opIsz: begin
                                expMb   <= word + 12'd1;
                                mbKnown <= 1'b1;
                            end
                            opDca: begin
                                expMb   <= ac;
                                mbKnown <= acKnown;
                            end
                            opJms: begin
                                expMb   <= pc;        // return address
                                mbKnown <= pcKnown;
                            end
                            default: mbKnown <= 1'b0;
                        endcase
                    end
                end
                default: ;
            endcase
        end else if (i_phase.endTs3) begin
            case (i_majorState)
                msFetch: begin
                    if (o_irKnown && (op == opJmp)) begin
                        if (!o_ir[indirectBit]) begin
                            pc      <= ea;
                            pcKnown <= eaKnown;
                        end
                    end else if (o_irKnown && (op == opOpr) && !o_ir[oprGroupBit]) begin
                        {link, ac} <= g1Out;
                        acKnown    <= acKnown | o_ir[claBit];
                        pc         <= pc + 12'd1;
                    end else begin
                        if (o_irKnown && (op == opOpr)) acKnown <= 1'b0;
                        pc <= pc + 12'd1;
                    end
                end
                msDefer: begin
                    if (o_irKnown && (op == opJmp)) begin
                        pc      <= ea;            // indirect jmp target
                        pcKnown <= 1'b1;
                    end
                end
                msExec: begin
                    if (o_irKnown) begin
                        case (op)
                            opAnd: ac <= ac & word;
                            opTad: {link, ac} <= {link, ac} + {1'b0, word};
                            opIsz: if (expMb == '0) pc <= pc + 12'd1;
                            opDca: begin
                                ac      <= '0;
                                acKnown <= 1'b1;
                            end
                            opJms: begin
                                pc      <= ea + 12'd1;
                                pcKnown <= eaKnown;
                            end
                            default: ;
                        endcase
                    end
                end
                default: ;
            endcase
        end else if (i_phase.acCapture) begin
            if (!acKnown) begin
                ac      <= i_bus.ac;
                acKnown <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/pdp8Shadow.sv ====
`timescale 1ns/1ps

module pdp8Shadow import pdpIsaPkg::*, shadowPkg::*; #(
    parameter int DECIDE_STEP = 8,
    parameter int COUNT_WIDTH = 4
) (
    input  logic      CLOCK,
    input  logic      RESET,
    input  logic      i_step,
    input  pdpBusT    i_bus,
    output errorBitsT o_errorBits,
    output logic      o_error
);

    logic [COUNT_WIDTH-1:0] count;
    logic                   clear;
    phaseT                  phase;
    majorStateT             majorState;
    logic                   irKnown;
    wordT                   ir;
    errorBitsT              stateRaise, shadowRaise;
    errorBitsT              raise;

    assign raise = stateRaise | shadowRaise;

    cycleTimer #(.COUNT_WIDTH(COUNT_WIDTH)) u_timer (
        .i_CLOCK(CLOCK), .i_RESET(RESET), .i_step(i_step), .i_clear(clear), .o_count(count)
    );

    timeStateTracker #(.DECIDE_STEP(DECIDE_STEP), .COUNT_WIDTH(COUNT_WIDTH)) u_tracker (
        .i_CLOCK(CLOCK), .i_RESET(RESET), .i_step(i_step), .i_bus(i_bus),
        .i_count(count), .i_raise(raise), .o_clear(clear), .o_timeState(),
        .o_phase(phase), .o_errorBits(o_errorBits), .o_error(o_error)
    );

    majorStateUnit u_major (
        .i_CLOCK(CLOCK), .i_RESET(RESET), .i_bus(i_bus), .i_phase(phase),
        .i_irKnown(irKnown), .i_ir(ir), .o_majorState(majorState), .o_raise(stateRaise)
    );

    shadowRegisters u_shadow (
        .i_CLOCK(CLOCK), .i_RESET(RESET), .i_bus(i_bus), .i_phase(phase),
        .i_majorState(majorState), .o_irKnown(irKnown), .o_ir(ir), .o_raise(shadowRaise)
    );

endmodule

// ==== testbench/pdpBusModel.svh ====
`ifndef PDP_BUS_MODEL_SVH
`define PDP_BUS_MODEL_SVH

// cpu side of the bus, included inside the testbench module
localparam int faultNone    = 0;
localparam int faultMa      = 1;   // wrong address in the cycle
localparam int faultAc      = 2;   // wrong ac shown in TS4
localparam int faultOverlap = 3;   // ts3 raised inside TS1
localparam int faultTs3     = 4;   // ts3 pulse inside TS4

wordT mem [0:4095];   // reference core memory
wordT pc, ac;         // reference cpu registers
logic link;

task automatic fillMemory();
    for (int a = 0; a < 4096; a++) begin
        mem[a] = wordT'(a * 5) ^ wordT'(a >> 4) ^ 12'o5252;   // every address bit matters
    end
endtask

task automatic holdSteps(input int n);
    repeat (n) @(negedge CLOCK);
endtask

// one memory cycle: TS1 6 steps, TS2 6, TS3 16, TS4 18
task automatic playCycle(input wordT ma, input wordT rd, input wordT wr,
                         input wordT acAfter, input int fault);
    @(negedge CLOCK);
    bus.ma   = (fault == faultMa) ? ma ^ 12'o0001 : ma;
    bus.memN = ~rd;                 // read data is active low
    bus.mb   = wr;
    bus.ts1  = 1'b1;
    for (int s = 1; s < 6; s++) begin
        @(negedge CLOCK);
        bus.ts3 = (fault == faultOverlap) && (s == 3);
    end
    @(negedge CLOCK);
    bus.ts1 = 1'b0;
    bus.ts3 = 1'b0;
    holdSteps(5);
    @(negedge CLOCK);
    bus.ts3 = 1'b1;
    holdSteps(15);
    @(negedge CLOCK);
    bus.ts3 = 1'b0;
    bus.ac  = (fault == faultAc) ? acAfter ^ 12'o4001 : acAfter;   // ac valid from TS4 on
    for (int s = 1; s < 18; s++) begin
        @(negedge CLOCK);
        bus.ts3 = (fault == faultTs3) && (s == 12);
    end
endtask

// start key: ac and link cleared, strobes low
task automatic pulseBusInit();
    @(negedge CLOCK);
    bus         = '0;
    bus.busInit = 1'b1;
    bus.run     = 1'b1;
    bus.deferN  = 1'b1;
    ac          = '0;
    link        = 1'b0;
    holdSteps(2);
    @(negedge CLOCK);
    bus.busInit = 1'b0;
    holdSteps(2);
endtask

`endif

// ==== testbench/pdp8ShadowTb.sv ====
`timescale 1ns/1ps

module pdp8ShadowTb import pdpIsaPkg::*, shadowPkg::*; #(
    parameter int SEED = 84731
);

    localparam int STEP_LIMIT = 4 * 40 * 46 + 2000;   // tests x cycles x steps plus margin

    logic      CLOCK;
    logic      RESET;
    logic      step;
    pdpBusT    bus;
    errorBitsT errorBits;
    logic      error;
    errorBitsT want, held;
    int        seed;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;

    pdp8Shadow #(.DECIDE_STEP(8), .COUNT_WIDTH(4)) i_dut (
        .CLOCK(CLOCK), .RESET(RESET), .i_step(step), .i_bus(bus),
        .o_errorBits(errorBits), .o_error(error)
    );

    `include "pdpBusModel.svh"

    initial begin
        CLOCK = 1'b0;
        forever #2 CLOCK = ~CLOCK;
    end

    always @(posedge CLOCK) begin
        cycles <= cycles + 1;
        if (cycles >= STEP_LIMIT) begin
            $display("timeout: run did not finish within %0d clock cycles", STEP_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // clears, complements, iac, then rotate
    task automatic applyGroup1(input wordT instr);
        int turns;
        turns = instr[twiceBit] ? 2 : 1;
        if (instr[claBit]) ac = '0;
        if (instr[cllBit]) link = 1'b0;
        if (instr[cmaBit]) ac = ~ac;
        if (instr[cmlBit]) link = ~link;
        if (instr[iacBit]) {link, ac} = {link, ac} + 13'd1;
        repeat (turns) begin
            if (instr[rarBit]) {link, ac} = {ac[0], link, ac[11:1]};   // right through link
            else if (instr[ralBit]) {link, ac} = {ac, link};           // left through link
        end
    endtask

    // executes one instruction on the reference cpu, one bus cycle per major state
    task automatic runInstr(input wordT instr, input int fault, input logic mbFault);
        opcodeT      op;
        wordT        ea, rd, wr, oldPc;
        logic [12:0] sum;
        op    = opcodeT'(instr[11:9]);
        oldPc = pc;
        ea    = {instr[currentPageBit] ? pc[11:7] : 5'b0, instr[6:0]};
        if (op == opOpr) applyGroup1(instr);
        if (op != opJmp) pc = pc + 12'd1;
        else if (!instr[indirectBit]) pc = ea;
        playCycle(oldPc, instr, instr, ac, fault);
        if ((op <= opJmp) && instr[indirectBit]) begin
            rd = mem[ea];
            // pointers in 0010..0017 step before use
            wr = ((ea >= autoIndexBase) && (ea <= autoIndexBase + 12'd7)) ? rd + 12'd1 : rd;
            mem[ea] = wr;
            playCycle(ea, rd, mbFault ? rd : wr, ac, faultNone);
            ea = wr;
            if (op == opJmp) pc = ea;
        end
        if (op <= opJms) begin
            rd = mem[ea];
            case (op)
                opAnd: begin
                    wr = rd;
                    ac = ac & rd;
                end
                opTad: begin
                    wr  = rd;
                    sum = {1'b0, ac} + {1'b0, rd};
                    ac  = sum[11:0];
                    if (sum[12]) link = ~link;       // carry out complements the link
                end
                opIsz: begin
                    wr = rd + 12'd1;
                    if (wr == '0) pc = pc + 12'd1;   // skip
                end
                opDca: begin
                    wr = ac;
                    ac = '0;
                end
                default: begin
                    wr = pc;                         // jms stores return address
                    pc = ea + 12'd1;
                end
            endcase
            mem[ea] = wr;
            playCycle(ea, rd, wr, ac, faultNone);
        end
    endtask

    function automatic wordT randomMemRef();
        wordT w;
        w        = wordT'($random(seed));
        w[11:9]  = 3'({$random(seed)} % 6);          // and .. jmp
        return w;
    endfunction

    function automatic wordT randomGroup1();
        wordT w;
        int   r;
        w = 12'o7000 | (wordT'($random(seed)) & 12'o0361);   // cla cll cma cml iac
        r = {$random(seed)} % 5;
        case (r)
            1: w[rarBit] = 1'b1;
            2: w = w | 12'o0012;    // rtr
            3: w[ralBit] = 1'b1;
            4: w = w | 12'o0006;    // rtl
            default: ;
        endcase
        return w;
    endfunction

    task automatic expectClean(input string what);
        checks++;
        assert (!error && (errorBits == '0)) else begin
            errors++;
            $display("** Error at %0t: %s raised flags %b", $time, what, errorBits);
        end
    endtask

    task automatic waitForFlags(input errorBitsT expected, input string what);
        int n;
        n = 0;
        while (!error && (n < 100)) begin
            @(negedge CLOCK);
            n++;
        end
        checks++;
        assert (errorBits == expected) else begin
            errors++;
            $display("** Error at %0t: %s gave flags %b, expected %b",
                     $time, what, errorBits, expected);
        end
    endtask

    initial begin
        seed       = SEED;
        RESET      = 1'b1;
        step       = 1'b1;          // every clock is a step
        bus        = '0;
        bus.run    = 1'b1;
        bus.deferN = 1'b1;
        pc         = 12'o0200;
        ac         = '0;
        link       = 1'b0;
        fillMemory();
        repeat (4) @(posedge CLOCK);
        @(negedge CLOCK);
        RESET = 1'b0;

        // random memory reference program
        pulseBusInit();
        repeat (12) begin
            runInstr(randomMemRef(), faultNone, 1'b0);
            expectClean("memory reference program");
        end

        // group 1 operate, then a wrong ac in TS4
        repeat (10) begin
            runInstr(randomGroup1(), faultNone, 1'b0);
            expectClean("group 1 opr");
        end
        runInstr(randomGroup1(), faultAc, 1'b0);
        runInstr(12'o7000, faultNone, 1'b0);     // next ts1 exposes the ac
        want            = '0;
        want.acMismatch = 1'b1;
        waitForFlags(want, "wrong ac on bus");

        // auto index through 0010..0017
        pulseBusInit();
        for (int k = 0; k < 3; k++) begin
            runInstr({3'({$random(seed)} % 4), 2'b10, 7'o10 + 7'(k)}, faultNone, 1'b0);
            expectClean("auto index");
        end
        runInstr(12'o1413, faultNone, 1'b1);     // tad i 13 with unincremented pointer
        want            = '0;
        want.mbMismatch = 1'b1;
        waitForFlags(want, "unincremented auto index");

        // wrong fetch address, flags held until init
        pulseBusInit();
        repeat (3) runInstr(randomMemRef(), faultNone, 1'b0);
        runInstr(12'o7000, faultMa, 1'b0);
        want            = '0;
        want.maMismatch = 1'b1;
        waitForFlags(want, "wrong fetch address");
        held = errorBits;
        repeat (3) runInstr(randomGroup1(), faultAc, 1'b0);   // acMismatch unless frozen
        checks++;
        assert (errorBits == held) else begin
            errors++;
            $display("** Error at %0t: frozen flags changed to %b", $time, errorBits);
        end
        pulseBusInit();
        expectClean("bus init after fault");

        // strobe faults
        runInstr(12'o7000, faultOverlap, 1'b0);
        want           = '0;
        want.tsOverlap = 1'b1;
        waitForFlags(want, "ts1 and ts3 together");
        pulseBusInit();
        runInstr(12'o7000, faultTs3, 1'b0);
        want          = '0;
        want.ts3InTs4 = 1'b1;
        waitForFlags(want, "ts3 pulse in TS4");
        pulseBusInit();
        expectClean("final bus init");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/pdpIsaPkg.sv
verilog/shadowPkg.sv
verilog/cycleTimer.sv
verilog/timeStateTracker.sv
verilog/majorStateUnit.sv
verilog/shadowRegisters.sv
verilog/pdp8Shadow.sv
+incdir+testbench
testbench/pdp8ShadowTb.sv

// ==== Makefile ====
# Verilator build and run for the PDP-8 shadow checker

VERILATOR ?= verilator
TOP       ?= pdp8ShadowTb
LOG       ?= sim.log
SEED      ?= 84731
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing -Wno-fatal -f build.f --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
